//--- tcb_pkg.sv
/*
  TCB bus widths, request and response structs,
  and the byte order enum of command data
*/

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // address width
  localparam int unsigned TCB_ABW = 32;
  // number of byte lanes
  localparam int unsigned TCB_BEW = 4;
  // lane width
  localparam int unsigned TCB_SLW = 8;

  // byte order of command data
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_endian_t;

  //////////////////////////////////////////////////////////////////////
  // transfer request and response
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                             wen;  // write enable
    logic                             lck;  // locked to next transfer
    logic [TCB_ABW-1:0]               adr;  // word aligned
    logic [TCB_BEW-1:0]               ben;
    logic [TCB_BEW-1:0][TCB_SLW-1:0]  wdt;
  } tcb_req_t;

  typedef struct packed {
    logic [TCB_BEW-1:0][TCB_SLW-1:0]  rdt;
    logic                             err;
  } tcb_rsp_t;

endpackage

//--- access_pkg.sv
/*
  access engine opcode and size enums,
  command and result structs
*/

package access_pkg;

  // widest access in bytes
  localparam int unsigned ACC_BYTES = 8;

  typedef enum logic {
    ACC_READ  = 1'b0,
    ACC_WRITE = 1'b1
  } access_op_t;

  // log2 of the byte count
  typedef enum logic [1:0] {
    SIZ_1 = 2'd0,
    SIZ_2 = 2'd1,
    SIZ_4 = 2'd2,
    SIZ_8 = 2'd3
  } access_siz_t;

  // one command from the host side
  typedef struct packed {
    access_op_t                                  op;
    access_siz_t                                 siz;
    tcb_pkg::tcb_endian_t                        ndn;
    logic [tcb_pkg::TCB_ABW-1:0]                 adr;
    logic [ACC_BYTES-1:0][tcb_pkg::TCB_SLW-1:0]  dat;
  } access_cmd_t;

  // collected result, valid with done
  typedef struct packed {
    logic [ACC_BYTES-1:0][tcb_pkg::TCB_SLW-1:0]  dat;
    logic                                        err;
  } access_res_t;

endpackage

//--- tcb_access_fsm.sv
/*
  access engine control FSM
  accepts commands, raises vld per transfer, waits for responses
*/

`timescale 1ns/1ps

module tcb_access_fsm (
  input  logic                    tcb,
  input  logic                    reset,
  // command side
  input  logic                    cmd_vld,
  input  access_pkg::access_siz_t siz,
  input  logic                    misaligned,
  output logic                    cmd_rdy,
  // bus handshake
  input  logic                    rdy,
  output logic                    vld,
  // counter status
  input  logic                    last_req,
  input  logic                    last_rsp,
  // strobes
  output logic                    issue,
  output logic                    start,
  output logic                    done
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RSP,
    FINISH
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   bad;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  assign cmd_rdy = (state == IDLE);
  assign start   = cmd_vld & cmd_rdy;
  assign vld     = (state == REQ);
  // one transfer per cycle with vld and rdy
  assign issue   = vld & rdy;
  assign done    = (state == FINISH);

  // byte accesses can never be misaligned
  assign bad = misaligned & (siz != access_pkg::SIZ_1);

  //////////////////////////////////////////////////////////////////////
  // state transitions
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // misaligned command skips the bus
        if (start) begin
          state_nxt = bad ? FINISH : REQ;
        end
      end
      REQ: begin
        // second transfer follows right after the first
        if (issue && last_req) begin
          state_nxt = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (last_rsp) begin
          state_nxt = FINISH;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge tcb) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- tcb_transfer_counter.sv
/*
  transfer and response counters for the active command
*/

`timescale 1ns/1ps

module tcb_transfer_counter (
  input  logic                    tcb,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    issue,
  input  logic                    rsp_vld,
  input  access_pkg::access_siz_t siz,
  output logic                    req_idx,
  output logic                    last_req,
  output logic                    last_rsp
);

  // two transfers for an 8 byte command, one otherwise
  logic wide;
  // responses returned so far
  logic rsp_idx;

  assign last_req = (req_idx == wide);
  // pulse on the final response only
  assign last_rsp = rsp_vld & (rsp_idx == wide);

  always_ff @(posedge tcb) begin
    if (reset) begin
      wide    <= 1'b0;
      req_idx <= 1'b0;
      rsp_idx <= 1'b0;
    end else if (start) begin
      wide    <= (siz == access_pkg::SIZ_8);
      req_idx <= 1'b0;
      rsp_idx <= 1'b0;
    end else begin
      // counted apart, a response can lag behind the next issue
      if (issue && !last_req) begin
        req_idx <= 1'b1;
      end
      if (rsp_vld && !last_rsp) begin
        rsp_idx <= 1'b1;
      end
    end
  end

endmodule

//--- tcb_lane_pack.sv
/*
  command register, lane mapping of write data and byte enables,
  transfer address and misalignment check
*/

`timescale 1ns/1ps

module tcb_lane_pack (
  input  logic                    tcb,
  input  logic                    reset,
  input  logic                    start,
  input  access_pkg::access_cmd_t cmd,
  input  logic                    req_idx,
  input  logic                    last_req,
  output tcb_pkg::tcb_req_t       req,
  output logic                    misaligned
);

  localparam int unsigned ABW = tcb_pkg::TCB_ABW;

  access_pkg::access_cmd_t cmd_q;
  logic [3:0]              nbytes;

  always_ff @(posedge tcb) begin
    if (reset) begin
      cmd_q <= '0;
    end else if (start) begin
      cmd_q <= cmd;
    end
  end

  assign nbytes = 4'd1 << cmd_q.siz;

  //////////////////////////////////////////////////////////////////////
  // request of the current transfer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    logic [1:0] lane;
    logic [2:0] src;
    req     = '0;
    req.wen = (cmd_q.op == access_pkg::ACC_WRITE);
    // lock held until the last transfer
    req.lck = ~last_req;
    req.adr = {cmd_q.adr[ABW-1:2], 2'b00} + ABW'({req_idx, 2'b00});
    for (int i = 0; i < access_pkg::ACC_BYTES; i++) begin
      // memory mode, byte sits on its address lane
      lane = cmd_q.adr[1:0] + 2'(i);
      src  = (cmd_q.ndn == tcb_pkg::TCB_BIG) ? 3'(nbytes - 1 - i) : 3'(i);
      if ((i < nbytes) && ((i >= 4) == req_idx)) begin
        req.ben[lane] = 1'b1;
        req.wdt[lane] = cmd_q.dat[src];
      end
    end
  end

  // checked on the incoming command, used at acceptance
  always_comb begin
    case (cmd.siz)
      access_pkg::SIZ_2: misaligned = cmd.adr[0];
      access_pkg::SIZ_4: misaligned = |cmd.adr[1:0];
      access_pkg::SIZ_8: misaligned = |cmd.adr[2:0];
      default:           misaligned = 1'b0;
    endcase
  end

endmodule

//--- tcb_lane_unpack.sv
/*
  response collector, puts lanes back into command byte order
  and builds the result with the error flag
*/

`timescale 1ns/1ps

module tcb_lane_unpack (
  input  logic                    tcb,
  input  logic                    reset,
  input  logic                    start,
  input  access_pkg::access_cmd_t cmd,
  input  logic                    rsp_vld,
  input  tcb_pkg::tcb_rsp_t       rsp,
  input  logic                    misaligned,
  output access_pkg::access_res_t res
);

  access_pkg::access_siz_t siz_q;
  tcb_pkg::tcb_endian_t    ndn_q;
  logic [1:0]              off_q;
  logic                    rsp_idx;
  logic                    last;
  logic [3:0]              nbytes;
  // partial result between responses
  logic [access_pkg::ACC_BYTES-1:0][tcb_pkg::TCB_SLW-1:0] acc_dat;
  logic [access_pkg::ACC_BYTES-1:0][tcb_pkg::TCB_SLW-1:0] nxt_dat;
  logic                                                   acc_err;
  logic                                                   nxt_err;

  assign nbytes  = 4'd1 << siz_q;
  assign last    = (rsp_idx == (siz_q == access_pkg::SIZ_8));
  assign nxt_err = acc_err | rsp.err;

  // inverse of the lane mapping
  always_comb begin
    logic [1:0] lane;
    logic [2:0] pos;
    nxt_dat = acc_dat;
    for (int i = 0; i < access_pkg::ACC_BYTES; i++) begin
      lane = off_q + 2'(i);
      pos  = (ndn_q == tcb_pkg::TCB_BIG) ? 3'(nbytes - 1 - i) : 3'(i);
      if ((i < nbytes) && ((i >= 4) == rsp_idx)) begin
        nxt_dat[pos] = rsp.rdt[lane];
      end
    end
  end

  always_ff @(posedge tcb) begin
    if (reset) begin
      siz_q   <= access_pkg::SIZ_1;
      ndn_q   <= tcb_pkg::TCB_LITTLE;
      off_q   <= 2'b00;
      rsp_idx <= 1'b0;
      acc_err <= 1'b0;
      res     <= '0;
    end else if (start) begin
      siz_q   <= cmd.siz;
      ndn_q   <= cmd.ndn;
      off_q   <= cmd.adr[1:0];
      rsp_idx <= 1'b0;
      acc_err <= misaligned;
      // no bus transfer follows, result is final now
      if (misaligned) begin
        res <= '{dat: '0, err: 1'b1};
      end
    end else if (rsp_vld) begin
      acc_err <= nxt_err;
      if (!last) begin
        rsp_idx <= 1'b1;
      end else begin
        res <= '{dat: nxt_dat, err: nxt_err};
      end
    end
  end

  // cleared per command, unused bytes read back as zero
  always_ff @(posedge tcb) begin
    if (start) begin
      acc_dat <= '0;
    end else if (rsp_vld) begin
      acc_dat <= nxt_dat;
    end
  end

endmodule

//--- tcb_mem_sub.sv
/*
  TCB subordinate word memory
  byte enable writes, ready from hold, DLY stage response pipeline
*/

`timescale 1ns/1ps

module tcb_mem_sub #(
  parameter int unsigned DLY       = 1,
  parameter int unsigned MEM_WORDS = 256
)(
  input  logic              tcb,
  input  logic              reset,
  input  logic              hold,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

  localparam int unsigned AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [tcb_pkg::TCB_BEW-1:0][tcb_pkg::TCB_SLW-1:0] mem [MEM_WORDS];

  logic                         trn;
  logic [tcb_pkg::TCB_ABW-3:0]  wadr;
  logic                         in_range;
  tcb_pkg::tcb_rsp_t            rsp_d;
  // response pipeline
  logic [DLY-1:0]               pipe_vld;
  tcb_pkg::tcb_rsp_t            pipe_rsp [DLY];

  // back-pressure straight from hold
  assign rdy      = ~hold;
  assign trn      = vld & rdy;
  assign wadr     = req.adr[tcb_pkg::TCB_ABW-1:2];
  assign in_range = (32'(wadr) < MEM_WORDS);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (trn && req.wen && in_range) begin
      for (int b = 0; b < tcb_pkg::TCB_BEW; b++) begin
        if (req.ben[b]) begin
          mem[wadr[AW-1:0]][b] <= req.wdt[b];
        end
      end
    end
  end

  // read data only for in-range reads, zero otherwise
  assign rsp_d.rdt = (!req.wen && in_range) ? mem[wadr[AW-1:0]] : '0;
  assign rsp_d.err = ~in_range;

  //////////////////////////////////////////////////////////////////////
  // response delay
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      pipe_vld <= '0;
    end else begin
      pipe_vld[0] <= trn;
      for (int k = 1; k < DLY; k++) begin
        pipe_vld[k] <= pipe_vld[k-1];
      end
    end
  end

  always_ff @(posedge tcb) begin
    if (trn) begin
      pipe_rsp[0] <= rsp_d;
    end
    for (int k = 1; k < DLY; k++) begin
      pipe_rsp[k] <= pipe_rsp[k-1];
    end
  end

  assign rsp_vld = pipe_vld[DLY-1];
  assign rsp     = pipe_rsp[DLY-1];

endmodule

//--- tcb_access_top.sv
/*
  access subsystem top, engine blocks and memory subordinate
*/

`timescale 1ns/1ps

module tcb_access_top #(
  parameter int unsigned DLY       = 1,
  parameter int unsigned MEM_WORDS = 256
)(
  input  logic                    tcb,
  input  logic                    reset,
  // command side
  input  logic                    cmd_vld,
  input  access_pkg::access_cmd_t cmd,
  output logic                    cmd_rdy,
  output logic                    done,
  output access_pkg::access_res_t res,
  // memory back-pressure
  input  logic                    hold
);

  // bus between engine and memory
  logic              vld;
  logic              rdy;
  tcb_pkg::tcb_req_t req;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;

  // engine internal
  logic issue;
  logic start;
  logic misaligned;
  logic req_idx;
  logic last_req;
  logic last_rsp;

  tcb_access_fsm i_fsm (
    .tcb        (tcb),
    .reset      (reset),
    .cmd_vld    (cmd_vld),
    .siz        (cmd.siz),
    .misaligned (misaligned),
    .cmd_rdy    (cmd_rdy),
    .rdy        (rdy),
    .vld        (vld),
    .last_req   (last_req),
    .last_rsp   (last_rsp),
    .issue      (issue),
    .start      (start),
    .done       (done)
  );

  tcb_transfer_counter i_cnt (
    .tcb      (tcb),
    .reset    (reset),
    .start    (start),
    .issue    (issue),
    .rsp_vld  (rsp_vld),
    .siz      (cmd.siz),
    .req_idx  (req_idx),
    .last_req (last_req),
    .last_rsp (last_rsp)
  );

  tcb_lane_pack i_pack (
    .tcb        (tcb),
    .reset      (reset),
    .start      (start),
    .cmd        (cmd),
    .req_idx    (req_idx),
    .last_req   (last_req),
    .req        (req),
    .misaligned (misaligned)
  );

  tcb_lane_unpack i_unpack (
    .tcb        (tcb),
    .reset      (reset),
    .start      (start),
    .cmd        (cmd),
    .rsp_vld    (rsp_vld),
    .rsp        (rsp),
    .misaligned (misaligned),
    .res        (res)
  );

  tcb_mem_sub #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) i_mem (
    .tcb     (tcb),
    .reset   (reset),
    .hold    (hold),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule

//--- tcb_access_properties.sv
/*
  bus handshake, response timing and lock assertions
  bound into the access subsystem top
*/

`timescale 1ns/1ps

module tcb_access_properties #(
  parameter int unsigned DLY = 1
)(
  input logic              tcb,
  input logic              reset,
  input logic              vld,
  input logic              rdy,
  input tcb_pkg::tcb_req_t req,
  input logic              rsp_vld,
  input logic              done
);

  // stalled request keeps vld and its payload
  assert property (@(posedge tcb) disable iff (reset)
    (vld && !rdy) |=> (vld && $stable(req)))
    else $error("request changed while stalled");

  // each transfer answered DLY cycles later
  assert property (@(posedge tcb) disable iff (reset)
    $past(vld && rdy, DLY) |-> rsp_vld)
    else $error("response missing after transfer");

  // no response without a transfer
  assert property (@(posedge tcb) disable iff (reset)
    rsp_vld |-> $past(vld && rdy, DLY))
    else $error("response without transfer");

  // locked transfer is followed by another request
  assert property (@(posedge tcb) disable iff (reset)
    (vld && rdy && req.lck) |=> vld)
    else $error("lock released early");

  assert property (@(posedge tcb) disable iff (reset)
    !(done && vld))
    else $error("done while request pending");

endmodule

bind tcb_access_top tcb_access_properties #(
  .DLY (DLY)
) i_props (
  .tcb     (tcb),
  .reset   (reset),
  .vld     (vld),
  .rdy     (rdy),
  .req     (req),
  .rsp_vld (rsp_vld),
  .done    (done)
);

//--- tcb_access_tb.sv
/*
  directed testbench for the TCB access subsystem
  clock, reset, access task with byte model, LFSR, watchdog
*/

`timescale 1ns/1ps

module tcb_access_tb;

  localparam int DLY        = 2;
  localparam int MEM_WORDS  = 256;
  // accesses issued by all tests together
  localparam int NUM_ACCESS = 61;
  // longest hold run allowed for per transfer
  localparam int HOLD_RUN   = 32;
  localparam int WORST_LAT  = 2 * (HOLD_RUN + 1) + DLY + 4;
  localparam int MAX_CYCLES = NUM_ACCESS * WORST_LAT + 20;

  logic                    tcb;
  logic                    reset;
  logic                    cmd_vld;
  access_pkg::access_cmd_t cmd;
  logic                    hold;
  logic                    cmd_rdy;
  logic                    done;
  access_pkg::access_res_t res;

  // byte model of the memory
  logic [7:0]  model [MEM_WORDS*4];
  logic [31:0] lfsr;
  int          errors   = 0;
  int          cycles   = 0;
  int          last_lat = 0;

  tcb_access_top #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) i_dut (
    .tcb     (tcb),
    .reset   (reset),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .cmd_rdy (cmd_rdy),
    .done    (done),
    .res     (res),
    .hold    (hold)
  );

  initial tcb = 1'b0;
  always #10 tcb = ~tcb;

  // watchdog, ends a hung run
  always @(posedge tcb) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, no done from the DUT within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit
  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic fail_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic drive_hold(input bit busy);
    logic [63:0] b;
    if (busy) begin
      rand_bits(1, b);
      hold = b[0];
    end else begin
      hold = 1'b0;
    end
  endtask

  // one command, model update and result check
  task automatic run_access(
    input access_pkg::access_op_t  op,
    input access_pkg::access_siz_t siz,
    input tcb_pkg::tcb_endian_t    ndn,
    input logic [31:0]             adr,
    input logic [63:0]             dat,
    input bit                      busy
  );
    int          n;
    int          pos;
    logic [31:0] a;
    logic        mis;
    logic [63:0] exp_dat;
    logic        exp_err;
    n       = 1 << siz;
    mis     = (adr % 32'(n)) != 0;
    exp_dat = '0;
    exp_err = mis;
    for (int i = 0; i < n; i++) begin
      a   = adr + 32'(i);
      pos = (ndn == tcb_pkg::TCB_BIG) ? n - 1 - i : i;
      if (!mis && (a >> 2) < MEM_WORDS) begin
        // writes answer with zero data
        if (op == access_pkg::ACC_WRITE) begin
          model[a] = dat[8*pos +: 8];
        end else begin
          exp_dat[8*pos +: 8] = model[a];
        end
      end else if (!mis) begin
        exp_err = 1'b1;
      end
    end
    @(negedge tcb);
    cmd.op  = op;
    cmd.siz = siz;
    cmd.ndn = ndn;
    cmd.adr = adr;
    cmd.dat = dat;
    cmd_vld = 1'b1;
    drive_hold(busy);
    while (cmd_rdy !== 1'b1) begin
      @(negedge tcb);
      drive_hold(busy);
    end
    @(negedge tcb);
    cmd_vld  = 1'b0;
    last_lat = 1;
    while (done !== 1'b1) begin
      drive_hold(busy);
      @(negedge tcb);
      last_lat++;
    end
    hold = 1'b0;
    check_value("res.dat", res.dat, exp_dat);
    check_value("res.err", 64'(res.err), 64'(exp_err));
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_value("cmd_rdy", 64'(cmd_rdy), 64'd1);
    check_value("done", 64'(done), 64'd0);
    check_value("vld", 64'(i_dut.vld), 64'd0);
    check_value("rsp_vld", 64'(i_dut.rsp_vld), 64'd0);
  endtask

  // known contents for the first 16 words
  task automatic fill_words();
    logic [63:0] d;
    for (int w = 0; w < 16; w++) begin
      rand_bits(32, d);
      run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
                 32'(4 * w), d, 1'b0);
    end
  endtask

  task automatic test_word_roundtrip();
    logic [63:0] d;
    rand_bits(32, d);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               32'h10, d, 1'b0);
    check_value("done latency", 64'(last_lat), 64'(DLY + 2));
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               32'h10, '0, 1'b0);
    check_value("done latency", 64'(last_lat), 64'(DLY + 2));
    check_value("res.dat", res.dat, {32'h0, d[31:0]});
  endtask

  task automatic test_lane_offsets();
    logic [63:0] d;
    for (int off = 0; off < 4; off++) begin
      rand_bits(8, d);
      run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_1, tcb_pkg::TCB_LITTLE,
                 32'h20 + 32'(off), d, 1'b0);
      run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
                 32'h20, '0, 1'b0);
    end
    // halfwords on lanes 0-1 and 2-3
    for (int off = 0; off < 4; off += 2) begin
      rand_bits(16, d);
      run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_2, tcb_pkg::TCB_LITTLE,
                 32'h24 + 32'(off), d, 1'b0);
      run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
                 32'h24, '0, 1'b0);
    end
  endtask

  task automatic test_big_endian();
    logic [63:0] d;
    rand_bits(32, d);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_4, tcb_pkg::TCB_BIG,
               32'h28, d, 1'b0);
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               32'h28, '0, 1'b0);
    check_value("res.dat", res.dat, {32'h0, d[7:0], d[15:8], d[23:16], d[31:24]});
  endtask

  task automatic test_wide_backpressure();
    logic [63:0]          d;
    logic [31:0]          adr;
    tcb_pkg::tcb_endian_t ndn;
    for (int k = 0; k < 6; k++) begin
      rand_bits(64, d);
      adr = 32'h40 + 32'(8 * k);
      ndn = k[0] ? tcb_pkg::TCB_BIG : tcb_pkg::TCB_LITTLE;
      run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_8, ndn, adr, d, 1'b1);
      run_access(access_pkg::ACC_READ, access_pkg::SIZ_8, ndn, adr, '0, 1'b1);
      check_value("res.dat", res.dat, d);
      // same read without hold
      run_access(access_pkg::ACC_READ, access_pkg::SIZ_8, ndn, adr, '0, 1'b0);
      check_value("res.dat", res.dat, d);
      // second transfer right behind the first, done after its response
      check_value("done latency", 64'(last_lat), 64'(DLY + 3));
    end
  endtask

  task automatic test_misaligned();
    logic [63:0] d;
    rand_bits(64, d);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_2, tcb_pkg::TCB_LITTLE,
               32'h05, d, 1'b0);
    check_value("done latency", 64'(last_lat), 64'd1);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               32'h06, d, 1'b0);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_8, tcb_pkg::TCB_LITTLE,
               32'h04, d, 1'b0);
    // model untouched, so reads expect the old words
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               32'h04, '0, 1'b0);
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               32'h08, '0, 1'b0);
  endtask

  task automatic test_out_of_range();
    logic [63:0] d;
    logic [31:0] adr;
    adr = 32'(MEM_WORDS * 4);
    rand_bits(64, d);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               adr, d, 1'b0);
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_4, tcb_pkg::TCB_LITTLE,
               adr, '0, 1'b0);
    check_value("res.err", 64'(res.err), 64'd1);
    check_value("res.dat", res.dat, 64'h0);
    run_access(access_pkg::ACC_WRITE, access_pkg::SIZ_8, tcb_pkg::TCB_LITTLE,
               adr + 32'h8, d, 1'b0);
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_8, tcb_pkg::TCB_LITTLE,
               adr + 32'h8, '0, 1'b0);
    check_value("res.dat", res.dat, 64'h0);
    // low words share index bits with the rejected ones, must keep old data
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_8, tcb_pkg::TCB_LITTLE,
               32'h0, '0, 1'b0);
    run_access(access_pkg::ACC_READ, access_pkg::SIZ_8, tcb_pkg::TCB_LITTLE,
               32'h8, '0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset   = 1'b1;
    cmd_vld = 1'b0;
    cmd     = '0;
    hold    = 1'b0;
    lfsr    = 32'd69625;
    repeat (2) @(posedge tcb);
    @(negedge tcb);
    reset = 1'b0;
    test_reset_state();
    fill_words();
    test_word_roundtrip();
    test_lane_offsets();
    test_big_endian();
    test_wide_backpressure();
    test_misaligned();
    test_out_of_range();
    repeat (4) @(negedge tcb);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- compile.f
tcb_pkg.sv
access_pkg.sv
tcb_access_fsm.sv
tcb_transfer_counter.sv
tcb_lane_pack.sv
tcb_lane_unpack.sv
tcb_mem_sub.sv
tcb_access_top.sv
tcb_access_properties.sv
tcb_access_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tcb_access_tb
FILELIST  = compile.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
